/* acc_pkg.sv */
package acc_pkg;

    ////////////////////////////////////////
    // Data path widths
    ////////////////////////////////////////

    // Feature word, signed
    localparam int FM_W  = 8;

    // One weight per row per pixel
    localparam int WT_W  = 8;

    // Row sum. 64 full-scale products stay well inside 24 bits
    localparam int ACC_W = 24;

    ////////////////////////////////////////
    // Word types
    ////////////////////////////////////////

    typedef logic signed [FM_W-1:0]  fm_word_t;   // Feature buffer word
    typedef logic signed [WT_W-1:0]  wt_word_t;   // Weight buffer word
    typedef logic signed [ACC_W-1:0] acc_word_t;  // Accumulator and drained sum

endpackage

/* ctrl_pkg.sv */
package ctrl_pkg;

    ////////////////////////////////////////
    // Controller phases
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        PH_IDLE   = 2'd0,  // Waiting for start
        PH_STREAM = 2'd1,  // One pixel read per cycle
        PH_SETTLE = 2'd2,  // Let the last products land
        PH_DRAIN  = 2'd3   // One row sum per cycle
    } sa_phase_e;

    ////////////////////////////////////////
    // Drain timing
    ////////////////////////////////////////

    // Cycles between the last pixel read and the first drained row.
    // Covers the buffer read register and the accumulate stage
    localparam int SETTLE_CYCLES = 4;

endpackage

/* sa_stream_if.sv */
`timescale 1ns/1ps

// Pixel read stream from the controller to both buffers
interface sa_stream_if #(
    parameter int ADDR_W = 6
);

    logic              rd_en;    // One strobe per pixel
    logic [ADDR_W-1:0] rd_addr;  // Pixel index
    logic              first;    // Pixel 0
    logic              last;     // Pixel len

    modport ctrl (
        output rd_en,
        output rd_addr,
        output first,
        output last
    );

    modport mem (
        input rd_en,
        input rd_addr,
        input first,
        input last
    );

endinterface

/* sa_ctrl.sv */
`timescale 1ns/1ps

module sa_ctrl
    import ctrl_pkg::*;
#(
    parameter int NUM_ROWS = 16,
    parameter int ADDR_W   = 6,
    parameter int ROW_W    = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic [ADDR_W-1:0] len,
    output logic              busy,
    output logic              acc_clear,
    output logic              drain_en,
    output logic [ROW_W-1:0]  drain_row,
    output logic              out_done,
    sa_stream_if.ctrl         st
);

    // Settle and drain share one counter with the rows after the gap
    localparam int SEQ_LEN = SETTLE_CYCLES + NUM_ROWS;
    localparam int SEQ_W   = $clog2(SEQ_LEN);

    sa_phase_e         phase;
    logic [ADDR_W-1:0] len_q;       // Last pixel index of this tile
    logic [ADDR_W-1:0] pix_cnt;
    logic [SEQ_W-1:0]  seq_cnt;
    logic              start_ok;
    logic              pix_end;
    logic              settle_end;
    logic              seq_end;
    logic              last_row_q;  // Last drain cycle, one cycle late

    assign start_ok = start && !busy;  // Extra starts mid-tile are dropped

    // Held until tile_done has gone out
    assign busy = (phase != PH_IDLE) || last_row_q || out_done;

    ////////////////////////////////////////
    // Phase register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= PH_IDLE;
        end else begin
            case (phase)
                PH_IDLE:   if (start_ok)   phase <= PH_STREAM;
                PH_STREAM: if (pix_end)    phase <= PH_SETTLE;
                PH_SETTLE: if (settle_end) phase <= PH_DRAIN;
                PH_DRAIN:  if (seq_end)    phase <= PH_IDLE;
                default:                   phase <= PH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            len_q <= len;
        end
    end

    ////////////////////////////////////////
    // Pixel loop
    ////////////////////////////////////////

    assign pix_end = (phase == PH_STREAM) && (pix_cnt == len_q);

    always_ff @(posedge clk) begin
        if (reset) begin
            pix_cnt <= '0;
        end else if (phase == PH_STREAM) begin
            if (pix_end) begin
                pix_cnt <= '0;  // Wrap for the next tile
            end else begin
                pix_cnt <= pix_cnt + 1'b1;
            end
        end
    end

    assign st.rd_en   = (phase == PH_STREAM);
    assign st.rd_addr = pix_cnt;
    assign st.first   = (phase == PH_STREAM) && (pix_cnt == '0);
    assign st.last    = pix_end;

    ////////////////////////////////////////
    // Settle and drain loop
    ////////////////////////////////////////

    assign settle_end = (phase == PH_SETTLE) && (seq_cnt == SEQ_W'(SETTLE_CYCLES - 1));
    assign seq_end    = (phase == PH_DRAIN) && (seq_cnt == SEQ_W'(SEQ_LEN - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            seq_cnt <= '0;
        end else if (phase == PH_SETTLE || phase == PH_DRAIN) begin
            if (seq_end) begin
                seq_cnt <= '0;
            end else begin
                seq_cnt <= seq_cnt + 1'b1;
            end
        end
    end

    assign drain_en  = (phase == PH_DRAIN);
    // Row index is the counter minus the settle gap
    assign drain_row = drain_en ? ROW_W'(seq_cnt - SEQ_W'(SETTLE_CYCLES)) : '0;

    // Clear lands before the first product and done trails the output register
    always_ff @(posedge clk) begin
        if (reset) begin
            acc_clear  <= 1'b0;
            last_row_q <= 1'b0;
            out_done   <= 1'b0;
        end else begin
            acc_clear  <= start_ok;
            last_row_q <= seq_end;
            out_done   <= last_row_q;  // Cycle after the last out_valid
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Full settle gap between the last pixel and the first row
    a_settle_gap: assert property (@(posedge clk) disable iff (reset)
        st.last |=> !drain_en [*SETTLE_CYCLES]);

endmodule

/* fm_buffer.sv */
`timescale 1ns/1ps

module fm_buffer
    import acc_pkg::*;
#(
    parameter int ADDR_W = 6
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              fm_wr_en,
    input  logic [ADDR_W-1:0] fm_wr_addr,
    input  fm_word_t          fm_wr_data,
    sa_stream_if.mem          st,
    output logic              fm_valid,
    output fm_word_t          fm_word
);

    localparam int DEPTH = 2 ** ADDR_W;

    fm_word_t mem [DEPTH];  // One tile of feature words

    // Host write port
    always_ff @(posedge clk) begin
        if (fm_wr_en) begin
            mem[fm_wr_addr] <= fm_wr_data;
        end
    end

    // Registered read, word follows rd_en by one cycle
    always_ff @(posedge clk) begin
        if (st.rd_en) begin
            fm_word <= mem[st.rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fm_valid <= 1'b0;
        end else begin
            fm_valid <= st.rd_en;
        end
    end

    // Host loads only between tiles
    a_no_write_in_stream: assert property (@(posedge clk) disable iff (reset)
        !(fm_wr_en && st.rd_en));

    // A tile always opens at pixel 0
    a_stream_opens_at_zero: assert property (@(posedge clk) disable iff (reset)
        $rose(st.rd_en) |-> st.first && (st.rd_addr == '0));

endmodule

/* wt_buffer.sv */
`timescale 1ns/1ps

module wt_buffer
    import acc_pkg::*;
#(
    parameter int NUM_ROWS = 16,
    parameter int ADDR_W   = 6,
    parameter int ROW_W    = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      wt_wr_en,
    input  logic [ADDR_W-1:0]         wt_wr_addr,
    input  logic [ROW_W-1:0]          wt_wr_row,
    input  wt_word_t                  wt_wr_data,
    sa_stream_if.mem                  st,
    output logic                      wt_valid,
    output wt_word_t [NUM_ROWS-1:0]   wt_vec
);

    localparam int DEPTH = 2 ** ADDR_W;

    ////////////////////////////////////////
    // One bank per output row
    ////////////////////////////////////////

    for (genvar r = 0; r < NUM_ROWS; r++) begin : g_bank
        wt_word_t bank [DEPTH];
        wt_word_t rd_q;

        always_ff @(posedge clk) begin
            if (wt_wr_en && (wt_wr_row == ROW_W'(r))) begin
                bank[wt_wr_addr] <= wt_wr_data;  // Host picks the bank by row
            end
        end

        // All banks read the same pixel together
        always_ff @(posedge clk) begin
            if (st.rd_en) begin
                rd_q <= bank[st.rd_addr];
            end
        end

        assign wt_vec[r] = rd_q;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wt_valid <= 1'b0;
        end else begin
            wt_valid <= st.rd_en;  // Lines up with fm_valid
        end
    end

    // Pixels come back to back until the last one
    a_stream_contiguous: assert property (@(posedge clk) disable iff (reset)
        st.rd_en && !st.last |=> st.rd_en && (st.rd_addr == $past(st.rd_addr) + 1'b1));

    a_stream_stops_after_last: assert property (@(posedge clk) disable iff (reset)
        st.rd_en && st.last |=> !st.rd_en);

endmodule

/* mac_array.sv */
`timescale 1ns/1ps

module mac_array
    import acc_pkg::*;
#(
    parameter int NUM_ROWS = 16,
    parameter int ROW_W    = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    acc_clear,
    input  logic                    fm_valid,
    input  fm_word_t                fm_word,
    input  wt_word_t [NUM_ROWS-1:0] wt_vec,
    input  logic                    drain_en,
    input  logic [ROW_W-1:0]        drain_row,
    output logic                    out_valid,
    output logic [ROW_W-1:0]        out_row,
    output acc_word_t               out_sum
);

    acc_word_t prod [NUM_ROWS];  // Feature times row weight
    acc_word_t acc  [NUM_ROWS];  // Running row sums

    ////////////////////////////////////////
    // Products
    ////////////////////////////////////////

    // Operands widened first so the signed product keeps all its bits
    for (genvar r = 0; r < NUM_ROWS; r++) begin : g_prod
        assign prod[r] = acc_word_t'(fm_word) * acc_word_t'(wt_vec[r]);
    end

    ////////////////////////////////////////
    // Accumulators
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || acc_clear) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                acc[r] <= '0;  // Fresh tile
            end
        end else if (fm_valid) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                acc[r] <= acc[r] + prod[r];
            end
        end
    end

    ////////////////////////////////////////
    // Drain output
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= drain_en;
        end
    end

    // Sum and its row index, one row per drain cycle
    always_ff @(posedge clk) begin
        if (drain_en) begin
            out_row <= drain_row;
            out_sum <= acc[drain_row];
        end
    end

    // Clear must come before the first product of the tile
    a_clear_before_data: assert property (@(posedge clk) disable iff (reset)
        !(fm_valid && acc_clear));

    // Accumulators stay put while rows are read out
    a_quiet_during_drain: assert property (@(posedge clk) disable iff (reset)
        drain_en |-> !fm_valid);

endmodule

/* sa_top.sv */
`timescale 1ns/1ps

module sa_top
    import acc_pkg::*;
#(
    parameter  int NUM_ROWS = 16,
    parameter  int ADDR_W   = 6,
    localparam int ROW_W    = (NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic [ADDR_W-1:0] len,          // Last pixel index
    input  logic              fm_wr_en,
    input  logic [ADDR_W-1:0] fm_wr_addr,
    input  fm_word_t          fm_wr_data,
    input  logic              wt_wr_en,
    input  logic [ADDR_W-1:0] wt_wr_addr,
    input  logic [ROW_W-1:0]  wt_wr_row,
    input  wt_word_t          wt_wr_data,
    output logic              busy,
    output logic              out_valid,
    output logic [ROW_W-1:0]  out_row,
    output acc_word_t         out_sum,
    output logic              tile_done
);

    logic                    acc_clear;
    logic                    drain_en;
    logic [ROW_W-1:0]        drain_row;
    logic                    fm_valid;
    fm_word_t                fm_word;
    wt_word_t [NUM_ROWS-1:0] wt_vec;

    sa_stream_if #(.ADDR_W(ADDR_W)) st_if ();  // Shared read stream

    sa_ctrl #(.NUM_ROWS(NUM_ROWS), .ADDR_W(ADDR_W), .ROW_W(ROW_W)) u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .len       (len),
        .busy      (busy),
        .acc_clear (acc_clear),
        .drain_en  (drain_en),
        .drain_row (drain_row),
        .out_done  (tile_done),
        .st        (st_if.ctrl)
    );

    ////////////////////////////////////////
    // Buffers, read at the same pixel
    ////////////////////////////////////////

    fm_buffer #(.ADDR_W(ADDR_W)) u_fm (
        .clk(clk), .reset(reset), .fm_wr_en(fm_wr_en), .fm_wr_addr(fm_wr_addr),
        .fm_wr_data(fm_wr_data), .st(st_if.mem), .fm_valid(fm_valid), .fm_word(fm_word)
    );

    // wt_valid tracks fm_valid exactly
    wt_buffer #(.NUM_ROWS(NUM_ROWS), .ADDR_W(ADDR_W), .ROW_W(ROW_W)) u_wt (
        .clk(clk), .reset(reset), .wt_wr_en(wt_wr_en), .wt_wr_addr(wt_wr_addr),
        .wt_wr_row(wt_wr_row), .wt_wr_data(wt_wr_data), .st(st_if.mem),
        .wt_valid(), .wt_vec(wt_vec)
    );

    mac_array #(.NUM_ROWS(NUM_ROWS), .ROW_W(ROW_W)) u_mac (
        .clk(clk), .reset(reset), .acc_clear(acc_clear), .fm_valid(fm_valid),
        .fm_word(fm_word), .wt_vec(wt_vec), .drain_en(drain_en), .drain_row(drain_row),
        .out_valid(out_valid), .out_row(out_row), .out_sum(out_sum)
    );

endmodule

/* tb_sa_top.sv */
`timescale 1ns/1ps

module tb_sa_top
    import acc_pkg::*;
    import ctrl_pkg::*;
;

    localparam int NUM_ROWS  = 16;
    localparam int ADDR_W    = 6;
    localparam int ROW_W     = 4;
    localparam int NUM_TILES = 5;

    ////////////////////////////////////////
    // Tile table
    ////////////////////////////////////////

    // Last pixel index, random data, extra start mid-tile
    localparam int TILE_LEN   [NUM_TILES] = '{7, 0, 12, 63, 7};
    localparam bit TILE_RAND  [NUM_TILES] = '{0, 1, 1, 1, 0};
    localparam bit TILE_EXTRA [NUM_TILES] = '{0, 0, 1, 0, 1};

    logic              clk = 1'b0;
    logic              reset;
    logic              start;
    logic [ADDR_W-1:0] len;
    logic              fm_wr_en;
    logic [ADDR_W-1:0] fm_wr_addr;
    fm_word_t          fm_wr_data;
    logic              wt_wr_en;
    logic [ADDR_W-1:0] wt_wr_addr;
    logic [ROW_W-1:0]  wt_wr_row;
    wt_word_t          wt_wr_data;
    logic              busy;
    logic              out_valid;
    logic [ROW_W-1:0]  out_row;
    acc_word_t         out_sum;
    logic              tile_done;

    int          fm_model [2**ADDR_W];
    int          wt_model [NUM_ROWS][2**ADDR_W];
    int          exp_sum  [NUM_ROWS];
    logic [15:0] lfsr = 16'd13;
    int          value_errs = 0;
    int          proto_errs = 0;
    int          cycles = 0;
    int          cycle_limit;
    int          rows_seen;
    int          done_cnt;
    bit          prev_valid;

    sa_top #(.NUM_ROWS(NUM_ROWS), .ADDR_W(ADDR_W)) i_dut (
        .clk(clk), .reset(reset), .start(start), .len(len),
        .fm_wr_en(fm_wr_en), .fm_wr_addr(fm_wr_addr), .fm_wr_data(fm_wr_data),
        .wt_wr_en(wt_wr_en), .wt_wr_addr(wt_wr_addr), .wt_wr_row(wt_wr_row),
        .wt_wr_data(wt_wr_data), .busy(busy), .out_valid(out_valid),
        .out_row(out_row), .out_sum(out_sum), .tile_done(tile_done)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;  // Taps 16 14 13 11
        end else begin
            return s >> 1;
        end
    endfunction

    task automatic take_byte(output logic [7:0] b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr[0];  // One step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic int run_limit();
        int n;
        n = 50;
        for (int t = 0; t < NUM_TILES; t++) begin
            n += TILE_LEN[t] + 1 + SETTLE_CYCLES + NUM_ROWS + 10;
            n += (TILE_LEN[t] + 1) * NUM_ROWS;  // Host writes
        end
        return n;
    endfunction

    // Features on the row 0 cycle and one weight per cycle
    task automatic load_tile(input int t);
        logic [7:0] b;
        for (int p = 0; p <= TILE_LEN[t]; p++) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                @(negedge clk);
                fm_wr_en = (r == 0);
                if (r == 0) begin
                    if (TILE_RAND[t]) begin
                        take_byte(b);
                    end else begin
                        b = 8'd1;
                    end
                    fm_wr_addr  = ADDR_W'(p);
                    fm_wr_data  = fm_word_t'(b);
                    fm_model[p] = $signed(b);
                end
                if (TILE_RAND[t]) begin
                    take_byte(b);
                end else begin
                    b = 8'(r);
                end
                wt_wr_en       = 1'b1;
                wt_wr_addr     = ADDR_W'(p);
                wt_wr_row      = ROW_W'(r);
                wt_wr_data     = wt_word_t'(b);
                wt_model[r][p] = $signed(b);
            end
        end
        @(negedge clk);
        fm_wr_en = 1'b0;
        wt_wr_en = 1'b0;
    endtask

    // Plain dot product per row
    task automatic expect_sums(input int t);
        for (int r = 0; r < NUM_ROWS; r++) begin
            exp_sum[r] = 0;
            for (int p = 0; p <= TILE_LEN[t]; p++) begin
                exp_sum[r] += fm_model[p] * wt_model[r][p];
            end
        end
    endtask

    task automatic check_outputs(input int t);
        if (out_valid) begin
            if (rows_seen >= NUM_ROWS) begin
                $display("Tile %0d gave an extra output row at %0d ns", t, $time);
                proto_errs++;
            end else begin
                if (rows_seen > 0 && !prev_valid) begin
                    $display("Tile %0d output rows are not consecutive", t);
                    proto_errs++;
                end
                if (out_row !== ROW_W'(rows_seen)) begin
                    $display("ERROR %0d ns: out_row expected %0d got %0d",
                             $time, rows_seen, out_row);
                    value_errs++;
                end
                if (out_sum !== acc_word_t'(exp_sum[rows_seen])) begin
                    $display("ERROR %0d ns: out_sum row %0d expected %0d got %0d",
                             $time, rows_seen, exp_sum[rows_seen], out_sum);
                    value_errs++;
                end
            end
            rows_seen++;
        end
        if (tile_done) begin
            done_cnt++;
            if (!prev_valid || out_valid || rows_seen != NUM_ROWS) begin
                $display("Tile %0d tile_done came at the wrong cycle", t);
                proto_errs++;
            end
        end
        prev_valid = out_valid;
    endtask

    task automatic run_tile(input int t);
        int waited;
        int window;
        int extra_at;
        waited     = 0;
        window     = TILE_LEN[t] + 1 + SETTLE_CYCLES + NUM_ROWS + 6;
        extra_at   = (TILE_LEN[t] + 1) / 2 + 1;
        rows_seen  = 0;
        done_cnt   = 0;
        prev_valid = 1'b0;
        @(negedge clk);
        start = 1'b1;
        len   = ADDR_W'(TILE_LEN[t]);
        @(negedge clk);
        start = 1'b0;
        if (busy !== 1'b1) begin
            $display("ERROR %0d ns: busy expected 1 got %b", $time, busy);
            value_errs++;
        end
        while (done_cnt == 0 && waited < window) begin
            @(negedge clk);
            check_outputs(t);
            start = 1'b0;
            if (TILE_EXTRA[t] && waited == extra_at) begin
                if (!busy) begin
                    $display("Tile %0d was not busy when the extra start came", t);
                    proto_errs++;
                end
                start = 1'b1;  // Ignored and len must not be taken
                len   = ADDR_W'(3);
            end
            waited++;
        end
        start = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_outputs(t);  // Nothing more may arrive
        end
        if (rows_seen != NUM_ROWS) begin
            $display("Tile %0d gave %0d rows instead of %0d", t, rows_seen, NUM_ROWS);
            proto_errs++;
        end
        if (done_cnt != 1) begin
            $display("Tile %0d pulsed tile_done %0d times instead of once", t, done_cnt);
            proto_errs++;
        end
        if (busy !== 1'b0) begin
            $display("ERROR %0d ns: busy expected 0 got %b", $time, busy);
            value_errs++;
        end
    endtask

    ////////////////////////////////////////
    // Timeout
    ////////////////////////////////////////

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("Value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
            $display("Some tests failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        cycle_limit = run_limit();
        reset       = 1'b1;
        start       = 1'b0;
        len         = '0;
        fm_wr_en    = 1'b0;
        fm_wr_addr  = '0;
        fm_wr_data  = '0;
        wt_wr_en    = 1'b0;
        wt_wr_addr  = '0;
        wt_wr_row   = '0;
        wt_wr_data  = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Quiet outputs before the first start
        repeat (2) begin
            @(negedge clk);
            if (out_valid !== 1'b0 || tile_done !== 1'b0 || busy !== 1'b0) begin
                $display("ERROR %0d ns: out_valid/tile_done/busy expected 000 got %b%b%b",
                         $time, out_valid, tile_done, busy);
                value_errs++;
            end
        end

        for (int t = 0; t < NUM_TILES; t++) begin
            load_tile(t);
            expect_sums(t);
            run_tile(t);
        end

        $display("Value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sources.f */
acc_pkg.sv
ctrl_pkg.sv
sa_stream_if.sv
sa_ctrl.sv
fm_buffer.sv
wt_buffer.sv
mac_array.sv
sa_top.sv
tb_sa_top.sv
